//--- src/vdp_pkg.sv
// ------------------------------
// Shared types for the cartridge VDP, 4 KiB on-chip VRAM
// Raster is a 32x24 test mode, one RGB332 byte per pixel
// ------------------------------
package vdp_pkg;

	// ------------------------------
	// Sizes and raster timing
	localparam int VRAM_AW     = 12;             // 4 KiB VRAM
	localparam int CLEAR_WORDS = 1 << VRAM_AW;   // Whole VRAM wiped after reset
	localparam int H_ACTIVE    = 32;             // Pixels per line
	localparam int V_ACTIVE    = 24;             // Visible lines
	localparam int H_TOTAL     = 48;
	localparam int V_TOTAL     = 30;
	localparam int H_SYNC      = 4;              // Pixel times
	localparam int V_SYNC      = 2;              // Lines

	// ------------------------------
	// Plain vectors
	typedef logic [VRAM_AW-1:0] vram_addr_t;
	typedef logic [7:0]         vdp_data_t;
	typedef logic [1:0]         port_t;
	typedef logic [1:0]         phase_t;       // enable_state slot
	typedef logic [2:0]         reg_index_t;
	typedef logic [4:0]         lcd_red_t;
	typedef logic [5:0]         lcd_green_t;
	typedef logic [4:0]         lcd_blue_t;

	// Memory slots inside one enable_state turn
	localparam phase_t PH_CPU   = 2'd0;         // Host request slot
	localparam phase_t PH_FETCH = 2'd2;         // Display read slot

	typedef enum logic {
		CLEARING,
		RUNNING
	} seq_state_t;

	// ------------------------------
	// Bundles
	typedef struct packed {
		logic      wr;
		port_t     port;
		vdp_data_t wdata;
	} cpu_access_t;

	typedef struct packed {
		logic       wr;
		vram_addr_t address;
		vdp_data_t  wdata;
	} vram_req_t;

	typedef struct packed {
		lcd_red_t   red;
		lcd_green_t green;
		lcd_blue_t  blue;
		logic       de;
		logic       hsync_n;
		logic       vsync_n;
	} lcd_pixel_t;

endpackage

//--- src/cart_bus_sync.sv
// ------------------------------
// Host must hold its strobe until twait is low
// Split td bus where tdir high means td_out is driven
// ------------------------------
`timescale 1ns/1ns

module cart_bus_sync (
	input                      clk,
	input                      w_n_reset,
	input                      n_ce,
	input                      n_twr,
	input                      n_trd,
	input  vdp_pkg::port_t     ta,
	input  vdp_pkg::vdp_data_t td_in,
	input                      ack,
	input  vdp_pkg::vdp_data_t rdata,
	output logic               req,
	output vdp_pkg::cpu_access_t access,
	output logic               twait,
	output vdp_pkg::vdp_data_t td_out,
	output logic               tdir
);
	import vdp_pkg::*;

	logic [1:0] ff_ce_sync;     // Two-stage strobe synchronizers
	logic [1:0] ff_wr_sync;
	logic [1:0] ff_rd_sync;
	logic       ff_held;        // Access seen but strobe not yet released
	logic       ff_req;
	logic       ff_tdir;
	logic       w_active;
	logic       w_start;

	// ------------------------------
	// Strobe synchronization
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_ce_sync <= 2'b11;                      // Idle high
			ff_wr_sync <= 2'b11;
			ff_rd_sync <= 2'b11;
		end
		else begin
			ff_ce_sync <= {ff_ce_sync[0], n_ce};
			ff_wr_sync <= {ff_wr_sync[0], n_twr};
			ff_rd_sync <= {ff_rd_sync[0], n_trd};
		end
	end

	assign w_active = !ff_ce_sync[1] && (!ff_wr_sync[1] || !ff_rd_sync[1]);
	assign w_start  = w_active && !ff_held;           // One start per host access

	// ------------------------------
	// Request and read-back control
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_held <= 1'b0;
			ff_req  <= 1'b0;
			ff_tdir <= 1'b0;
		end
		else begin
			if (w_start) begin
				ff_held <= 1'b1;
				ff_req  <= 1'b1;
			end
			else if (!w_active) begin
				ff_held <= 1'b0;                       // Host let go
				ff_tdir <= 1'b0;
			end
			if (ff_req && ack) begin
				ff_req  <= 1'b0;                       // Drops the cycle after ack
				ff_tdir <= !access.wr;                 // Drive td only for reads
			end
		end
	end

	// Captured transfer and read byte
	always_ff @(posedge clk) begin
		if (w_start) begin
			access.wr    <= !ff_wr_sync[1];
			access.port  <= ta;
			access.wdata <= td_in;
		end
		if (ff_req && ack && !access.wr)
			td_out <= rdata;
	end

	assign req   = ff_req;
	assign twait = ff_req;                            // Wait held while outstanding
	assign tdir  = ff_tdir;

	// No new access starts while a request is still outstanding
	a_req_after_release: assert property (@(posedge clk) disable iff (!w_n_reset)
		w_start |-> !ff_req);

endmodule

//--- src/vdp_port.sv
// ------------------------------
// Port 0 carries VRAM data and port 1 control and status
// Ports 2 and 3 are acked and ignored
// ------------------------------
`timescale 1ns/1ns

module vdp_port (
	input                          clk,
	input                          w_n_reset,
	input                          req,
	input  vdp_pkg::cpu_access_t   access,
	input                          mem_ack,
	input  vdp_pkg::vdp_data_t     mem_rdata,
	input                          vblank_start,
	output logic                   ack,
	output vdp_pkg::vdp_data_t     rdata,
	output logic                   mem_req,
	output vdp_pkg::vram_req_t     mem_access,
	output logic                   display_on,
	output logic [1:0]             name_page,
	output vdp_pkg::vdp_data_t     backdrop
);
	import vdp_pkg::*;

	vdp_data_t  ff_regs [0:(1 << $bits(reg_index_t))-1];   // Write-only registers
	vram_addr_t ff_addr;            // Auto-increment pointer
	vdp_data_t  ff_latch;           // First byte of a port 1 pair
	logic       ff_second;          // Next port 1 write is the second byte
	logic       ff_vblank;          // Status bit 7
	logic       ff_ack;
	logic       ff_mem_req;
	reg_index_t w_reg_index;
	logic       w_start;

	assign w_reg_index = reg_index_t'(access.wdata[2:0]);
	assign w_start     = req && !ff_ack && !ff_mem_req;   // Fresh host transfer

	// ------------------------------
	// Port decode and register file
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			for (int i = 0; i < (1 << $bits(reg_index_t)); i++)
				ff_regs[i] <= '0;
			ff_addr    <= '0;
			ff_second  <= 1'b0;
			ff_vblank  <= 1'b0;
			ff_ack     <= 1'b0;
			ff_mem_req <= 1'b0;
		end
		else begin
			ff_ack <= 1'b0;                          // One-cycle pulse
			if (vblank_start)
				ff_vblank <= 1'b1;
			if (ff_mem_req) begin
				if (mem_ack) begin                   // VRAM slot done
					ff_mem_req <= 1'b0;
					ff_ack     <= 1'b1;
					ff_addr    <= ff_addr + 1'b1;    // Wraps at 4 KiB
				end
			end
			else if (w_start) begin
				case (access.port)
					2'd0: ff_mem_req <= 1'b1;        // Latency set by sequencer
					2'd1: begin
						ff_ack <= 1'b1;
						if (!access.wr) begin
							ff_second <= 1'b0;           // Status read resets the pair
							ff_vblank <= vblank_start;
						end
						else if (!ff_second) begin
							ff_latch  <= access.wdata;
							ff_second <= 1'b1;
						end
						else begin
							ff_second <= 1'b0;
							if (access.wdata[7])
								ff_regs[w_reg_index] <= ff_latch;   // Register write
							else
								ff_addr <= {access.wdata[3:0], ff_latch}; // Address set
						end
					end
					default: ff_ack <= 1'b1;         // Unused ports
				endcase
			end
		end
	end

	// ------------------------------
	// Read data and VRAM request payload
	always_ff @(posedge clk) begin
		if (ff_mem_req && mem_ack)
			rdata <= mem_rdata;
		else if (w_start)
			rdata <= (access.port == 2'd1) ? {ff_vblank, 7'd0} : '0;
		if (w_start && access.port == 2'd0) begin
			mem_access.wr      <= access.wr;
			mem_access.address <= ff_addr;
			mem_access.wdata   <= access.wdata;
		end
	end

	assign ack        = ff_ack;
	assign mem_req    = ff_mem_req;
	assign display_on = ff_regs[1][6];        // R#1 BL bit
	assign name_page  = ff_regs[2][1:0];      // 1 KiB pages
	assign backdrop   = ff_regs[7];

	// VRAM ack answers only a pending request and never meets a host ack
	a_no_req_with_ack: assert property (@(posedge clk) disable iff (!w_n_reset)
		mem_ack |-> (ff_mem_req && !ff_ack));

endmodule

//--- src/vram_sequencer.sv
// ------------------------------
// Four-slot VRAM sequencer that stays busy while wiping VRAM after reset
// Host served in slot 0 and display read in slot 2
// ------------------------------
`timescale 1ns/1ns

module vram_sequencer (
	input                          clk,
	input                          w_n_reset,
	input                          mem_req,
	input  vdp_pkg::vram_req_t     mem_access,
	input  vdp_pkg::vram_addr_t    fetch_addr,
	output logic                   mem_ack,
	output vdp_pkg::vdp_data_t     mem_rdata,
	output vdp_pkg::phase_t        enable_state,
	output logic                   busy,
	output vdp_pkg::vdp_data_t     fetch_data
);
	import vdp_pkg::*;

	vdp_data_t  mem [0:CLEAR_WORDS-1];     // On-chip VRAM
	phase_t     ff_phase;
	seq_state_t ff_state;
	vram_addr_t ff_clear_addr;
	logic       ff_mem_ack;
	logic       w_cpu_slot;

	assign busy       = (ff_state == CLEARING);
	assign w_cpu_slot = !busy && ff_phase == PH_CPU && mem_req;

	// ------------------------------
	// Slot counter and clear FSM
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_phase      <= PH_CPU;
			ff_state      <= CLEARING;
			ff_clear_addr <= '0;
			ff_mem_ack    <= 1'b0;
		end
		else begin
			ff_phase   <= ff_phase + 1'b1;      // Free-running
			ff_mem_ack <= w_cpu_slot;
			if (ff_state == CLEARING) begin
				ff_clear_addr <= ff_clear_addr + 1'b1;
				if (ff_clear_addr == vram_addr_t'(CLEAR_WORDS - 1))
					ff_state <= RUNNING;
			end
		end
	end

	// ------------------------------
	// Memory array
	always_ff @(posedge clk) begin
		if (busy)
			mem[ff_clear_addr] <= '0;           // One word per cycle
		else if (w_cpu_slot && mem_access.wr)
			mem[mem_access.address] <= mem_access.wdata;
	end

	always_ff @(posedge clk) begin
		if (w_cpu_slot)
			mem_rdata <= mem[mem_access.address];   // Valid with mem_ack
		if (!busy && ff_phase == PH_FETCH)
			fetch_data <= mem[fetch_addr];          // Held until next slot 2
	end

	assign mem_ack      = ff_mem_ack;
	assign enable_state = ff_phase;

	// A request made during the wipe stays pending without an ack
	a_no_ack_clearing: assert property (@(posedge clk) disable iff (!w_n_reset)
		busy && mem_req |=> mem_req && !mem_ack);

endmodule

//--- src/video_timing.sv
// ------------------------------
// One pixel per enable_state turn, outputs lag the counters by one pixel
// Front porch equals the sync width on both axes
// ------------------------------
`timescale 1ns/1ns

module video_timing (
	input                          clk,
	input                          w_n_reset,
	input  vdp_pkg::phase_t        enable_state,
	input                          display_on,
	input  [1:0]                   name_page,
	input  vdp_pkg::vdp_data_t     backdrop,
	input  vdp_pkg::vdp_data_t     fetch_data,
	output vdp_pkg::vram_addr_t    fetch_addr,
	output logic                   vblank_start,
	output logic                   lcd_clk,
	output vdp_pkg::lcd_pixel_t    pixel
);
	import vdp_pkg::*;

	logic [$clog2(H_TOTAL)-1:0] ff_h;     // Column
	logic [$clog2(V_TOTAL)-1:0] ff_v;     // Line
	logic                       ff_vblank_start;
	lcd_pixel_t                 ff_pixel;
	logic                       w_active;
	logic                       w_hsync;
	logic                       w_vsync;
	vdp_data_t                  w_colour;

	assign w_active = (ff_h < H_ACTIVE) && (ff_v < V_ACTIVE);
	assign w_hsync  = (ff_h >= H_ACTIVE + H_SYNC) && (ff_h < H_ACTIVE + 2 * H_SYNC);
	assign w_vsync  = (ff_v >= V_ACTIVE + V_SYNC) && (ff_v < V_ACTIVE + 2 * V_SYNC);

	// Page base, then line and column
	assign fetch_addr = vram_addr_t'({name_page, 10'd0}) + vram_addr_t'(ff_v * H_ACTIVE)
		+ vram_addr_t'(ff_h);

	// Zero byte is transparent
	assign w_colour = (display_on && fetch_data != '0) ? fetch_data : backdrop;

	// ------------------------------
	// Raster counters
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_h            <= '0;
			ff_v            <= '0;
			ff_vblank_start <= 1'b0;
		end
		else begin
			ff_vblank_start <= (enable_state == PH_CPU) && (ff_h == H_TOTAL - 1)
				&& (ff_v == V_ACTIVE - 1);
			if (enable_state == PH_CPU) begin
				if (ff_h == H_TOTAL - 1) begin
					ff_h <= '0;
					ff_v <= (ff_v == V_TOTAL - 1) ? '0 : ff_v + 1'b1;
				end
				else
					ff_h <= ff_h + 1'b1;
			end
		end
	end

	// ------------------------------
	// Output pixel, RGB332 widened by repeating top bits
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			ff_pixel <= '{red: '0, green: '0, blue: '0, de: 1'b0, hsync_n: 1'b1, vsync_n: 1'b1};
		end
		else if (enable_state == PH_CPU) begin
			ff_pixel.de      <= w_active;
			ff_pixel.hsync_n <= !w_hsync;
			ff_pixel.vsync_n <= !w_vsync;
			ff_pixel.red     <= w_active ? {w_colour[7:5], w_colour[7:6]} : '0;
			ff_pixel.green   <= w_active ? {w_colour[4:2], w_colour[4:2]} : '0;
			ff_pixel.blue    <= w_active ? {w_colour[1:0], w_colour[1:0], w_colour[1]} : '0;
		end
	end

	assign pixel        = ff_pixel;
	assign vblank_start = ff_vblank_start;
	assign lcd_clk      = enable_state[1];      // High in slots 2 and 3

	a_de_outside_sync: assert property (@(posedge clk) disable iff (!w_n_reset)
		ff_pixel.de |-> (ff_pixel.hsync_n && ff_pixel.vsync_n));

endmodule

//--- src/vdp_cart_top.sv
// ------------------------------
// Cartridge VDP top, no PLL and reset taken as is
// ------------------------------
`timescale 1ns/1ns

module vdp_cart_top (
	input                          clk,
	input                          w_n_reset,
	input                          n_ce,
	input                          n_twr,
	input                          n_trd,
	input  vdp_pkg::port_t         ta,
	input  vdp_pkg::vdp_data_t     td_in,
	output vdp_pkg::vdp_data_t     td_out,
	output logic                   tdir,
	output logic                   twait,
	output logic                   lcd_clk,
	output logic                   lcd_de,
	output logic                   lcd_hsync,
	output logic                   lcd_vsync,
	output vdp_pkg::lcd_red_t      lcd_red,
	output vdp_pkg::lcd_green_t    lcd_green,
	output vdp_pkg::lcd_blue_t     lcd_blue
);
	import vdp_pkg::*;

	// ------------------------------
	// Internal links
	cpu_access_t w_access;
	logic        w_req;
	logic        w_ack;
	vdp_data_t   w_rdata;
	vram_req_t   w_mem_access;
	logic        w_mem_req;
	logic        w_mem_ack;
	vdp_data_t   w_mem_rdata;
	phase_t      w_enable_state;
	vram_addr_t  w_fetch_addr;
	vdp_data_t   w_fetch_data;
	logic        w_display_on;
	logic [1:0]  w_name_page;
	vdp_data_t   w_backdrop;
	logic        w_vblank_start;
	lcd_pixel_t  w_pixel;

	cart_bus_sync u_bus (
		.clk(clk), .w_n_reset(w_n_reset), .n_ce(n_ce), .n_twr(n_twr), .n_trd(n_trd),
		.ta(ta), .td_in(td_in), .ack(w_ack), .rdata(w_rdata), .req(w_req),
		.access(w_access), .twait(twait), .td_out(td_out), .tdir(tdir)
	);

	vdp_port u_port (
		.clk(clk), .w_n_reset(w_n_reset), .req(w_req), .access(w_access),
		.mem_ack(w_mem_ack), .mem_rdata(w_mem_rdata), .vblank_start(w_vblank_start),
		.ack(w_ack), .rdata(w_rdata), .mem_req(w_mem_req), .mem_access(w_mem_access),
		.display_on(w_display_on), .name_page(w_name_page), .backdrop(w_backdrop)
	);

	// Clear status reaches the host only as twait
	vram_sequencer u_seq (
		.clk(clk), .w_n_reset(w_n_reset), .mem_req(w_mem_req), .mem_access(w_mem_access),
		.fetch_addr(w_fetch_addr), .mem_ack(w_mem_ack), .mem_rdata(w_mem_rdata),
		.enable_state(w_enable_state), .busy(), .fetch_data(w_fetch_data)
	);

	video_timing u_video (
		.clk(clk), .w_n_reset(w_n_reset), .enable_state(w_enable_state),
		.display_on(w_display_on), .name_page(w_name_page), .backdrop(w_backdrop),
		.fetch_data(w_fetch_data), .fetch_addr(w_fetch_addr),
		.vblank_start(w_vblank_start), .lcd_clk(lcd_clk), .pixel(w_pixel)
	);

	// LCD pins
	assign lcd_de    = w_pixel.de;
	assign lcd_hsync = w_pixel.hsync_n;     // Active low
	assign lcd_vsync = w_pixel.vsync_n;
	assign lcd_red   = w_pixel.red;
	assign lcd_green = w_pixel.green;
	assign lcd_blue  = w_pixel.blue;

endmodule

//--- tb/tb_vdp_cart.sv
// ------------------------------
// Records are read from tb/vdp_input.txt under the project root
// Frame checks expect registers and VRAM to stay static during the frame
// ------------------------------
`timescale 1ns/1ns

module tb_vdp_cart;
	import vdp_pkg::*;

	logic               clk;
	logic               w_n_reset;
	logic               n_ce, n_twr, n_trd;       // Active-low host strobes
	port_t              ta;
	vdp_data_t          td_in;
	vdp_data_t          td_out;
	logic               tdir, twait;
	logic               lcd_clk, lcd_de, lcd_hsync, lcd_vsync;
	lcd_red_t           lcd_red;
	lcd_green_t         lcd_green;
	lcd_blue_t          lcd_blue;

	// Reference model of VRAM and registers
	vdp_data_t          model_vram [0:CLEAR_WORDS-1];
	vdp_data_t          model_regs [0:7];
	vram_addr_t         model_addr;
	vdp_data_t          model_latch;
	logic               model_second;             // Next port 1 byte completes a pair
	int                 mismatches;
	int                 failures;                 // Timeouts and other faults

	vdp_cart_top u_vdp_cart_top (
		.clk(clk), .w_n_reset(w_n_reset), .n_ce(n_ce), .n_twr(n_twr), .n_trd(n_trd),
		.ta(ta), .td_in(td_in), .td_out(td_out), .tdir(tdir), .twait(twait),
		.lcd_clk(lcd_clk), .lcd_de(lcd_de), .lcd_hsync(lcd_hsync), .lcd_vsync(lcd_vsync),
		.lcd_red(lcd_red), .lcd_green(lcd_green), .lcd_blue(lcd_blue)
	);

	always #20 clk = ~clk;                        // 40 ns period

	// ------------------------------
	// Compare and report
	task automatic check_byte(input string name, input vdp_data_t expected,
		input vdp_data_t actual);
		if (actual !== expected) begin
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
			mismatches++;
		end
	endtask

	// Sync and de are counted per frame instead
	task automatic check_pixel(input string name, input lcd_pixel_t expected,
		input lcd_pixel_t actual);
		if ({actual.red, actual.green, actual.blue} !==
			{expected.red, expected.green, expected.blue}) begin
			$display("MISMATCH %s expected %h/%h/%h actual %h/%h/%h", name, expected.red,
				expected.green, expected.blue, actual.red, actual.green, actual.blue);
			mismatches++;
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
			mismatches++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		failures++;
	endtask

	// ------------------------------
	// Host bus
	task automatic wait_twait_low(input string what, output logic ok);
		int n;
		n = 0;
		@(negedge clk);
		while (twait && n < 20000) begin       // Long enough for the VRAM wipe
			@(negedge clk);
			n++;
		end
		ok = !twait;
		if (!ok)
			report_timeout(what);
	endtask

	task automatic host_write(input port_t port, input vdp_data_t data);
		logic ok;
		@(posedge clk);
		ta    <= port;
		td_in <= data;
		n_ce  <= 1'b0;
		n_twr <= 1'b0;
		repeat (4) @(posedge clk);               // Past the synchronizer
		wait_twait_low("twait to drop after a write", ok);
		@(posedge clk);
		n_ce  <= 1'b1;
		n_twr <= 1'b1;
		repeat (3) @(posedge clk);               // Let the release reach the DUT
	endtask

	task automatic host_read(input port_t port, output vdp_data_t data);
		logic ok;
		@(posedge clk);
		ta    <= port;
		n_ce  <= 1'b0;
		n_trd <= 1'b0;
		repeat (4) @(posedge clk);
		wait_twait_low("twait to drop after a read", ok);
		data = td_out;                           // Held until strobe release
		if (ok && !tdir) begin
			$display("Read data was due but tdir stayed low");
			failures++;
		end
		@(posedge clk);
		n_ce  <= 1'b1;
		n_trd <= 1'b1;
		repeat (3) @(posedge clk);
	endtask

	// ------------------------------
	// Model updates from the port rules
	task automatic track_write(input port_t port, input vdp_data_t data);
		case (port)
			2'd0: begin
				model_vram[model_addr] = data;
				model_addr++;                        // 12-bit pointer wraps at 4 KiB
			end
			2'd1: begin
				if (!model_second) begin
					model_latch  = data;
					model_second = 1'b1;
				end
				else begin
					model_second = 1'b0;
					if (data[7])
						model_regs[data[2:0]] = model_latch;
					else
						model_addr = {data[3:0], model_latch};
				end
			end
			default: ;                               // Ignored ports
		endcase
	endtask

	task automatic track_read(input port_t port);
		if (port == 2'd0)
			model_addr++;
		else if (port == 2'd1)
			model_second = 1'b0;                     // Status read drops the pair
	endtask

	// ------------------------------
	// Raster
	task automatic wait_vsync_fall(output logic ok);
		logic prev;
		int   n;
		n  = 0;
		ok = 1'b0;
		@(negedge clk);
		prev = lcd_vsync;
		while (!ok && n < 8 * H_TOTAL * V_TOTAL) begin   // Two frames of cycles
			@(negedge clk);
			ok   = prev && !lcd_vsync;
			prev = lcd_vsync;
			n++;
		end
		if (!ok)
			report_timeout("lcd_vsync to fall");
	endtask

	// RGB332 fields widened by repeating their top bits
	function automatic lcd_pixel_t expand_colour(input vdp_data_t c);
		lcd_pixel_t p;
		logic [8:0] red_rep;
		logic [5:0] green_rep;
		logic [5:0] blue_rep;
		red_rep   = {3{c[7:5]}};                 // Field repeated past the pin width
		green_rep = {2{c[4:2]}};
		blue_rep  = {3{c[1:0]}};
		p         = '0;
		p.red     = red_rep[8:4];                // Top pin bits kept
		p.green   = green_rep;
		p.blue    = blue_rep[5:1];
		return p;
	endfunction

	task automatic check_frame(input string name);
		lcd_pixel_t expected, actual;
		vdp_data_t  fetched;
		vram_addr_t a;
		logic       ok, prev_clk, prev_de, prev_hs;
		int         samples, cycles, run, lines, hpulses;
		wait_vsync_fall(ok);
		if (!ok)
			return;
		samples  = 0;
		cycles   = 0;
		run      = 0;
		lines    = 0;
		hpulses  = 0;
		prev_clk = lcd_clk;
		prev_de  = 1'b0;
		prev_hs  = 1'b1;
		while (samples < H_TOTAL * V_TOTAL && cycles < 8 * H_TOTAL * V_TOTAL) begin
			@(negedge clk);
			cycles++;
			if (lcd_clk && !prev_clk) begin        // Outputs settled mid-pixel
				actual = {lcd_red, lcd_green, lcd_blue, lcd_de, lcd_hsync, lcd_vsync};
				if (lcd_de) begin
					a = vram_addr_t'(int'(model_regs[2][1:0]) * 1024 + lines * H_ACTIVE + run);
					fetched = model_vram[a];
					if (model_regs[1][6] && fetched != '0)
						expected = expand_colour(fetched);
					else
						expected = expand_colour(model_regs[7]);    // Backdrop
					run++;
				end
				else begin
					expected = '0;                       // Blanking is black
					if (prev_de) begin
						check_count({name, " de pixels in a line"}, H_ACTIVE, run);
						lines++;
						run = 0;
					end
				end
				check_pixel($sformatf("%s sample %0d", name, samples), expected, actual);
				if (prev_hs && !lcd_hsync)
					hpulses++;
				prev_de = lcd_de;
				prev_hs = lcd_hsync;
				samples++;
			end
			prev_clk = lcd_clk;
		end
		if (samples < H_TOTAL * V_TOTAL)
			report_timeout("a full frame of lcd_clk pixels");
		check_count({name, " lines with de"}, V_ACTIVE, lines);
		check_count({name, " hsync pulses"}, V_TOTAL, hpulses);
	endtask

	// ------------------------------
	// Record interpreter
	task automatic run_record(input logic [7:0] op, input port_t port,
		input logic [15:0] value, input vdp_data_t expected, input int record);
		vdp_data_t got;
		logic      ok;
		string     name;
		name = $sformatf("record %0d %s port %0d", record, op, port);
		case (op)
			"W": begin
				host_write(port, value[7:0]);
				track_write(port, value[7:0]);
			end
			"R": begin
				host_read(port, got);
				check_byte(name, expected, got);
				track_read(port);
			end
			"P": check_byte(name, expected, model_vram[vram_addr_t'(value)]);
			"V": wait_vsync_fall(ok);
			"F": check_frame(name);
			default: begin
				$display("Unknown op %s in record %0d", op, record);
				failures++;
			end
		endcase
	endtask

	initial begin
		int          fd, code, c, record;
		logic [7:0]  op;
		logic [15:0] port_f, value, expv;
		clk       = 1'b0;
		w_n_reset = 1'b0;
		n_ce      = 1'b1;
		n_twr     = 1'b1;
		n_trd     = 1'b1;
		ta        = '0;
		td_in     = '0;
		mismatches   = 0;
		failures     = 0;
		record       = 0;
		model_addr   = '0;
		model_latch  = '0;
		model_second = 1'b0;
		for (int i = 0; i < CLEAR_WORDS; i++)
			model_vram[i] = '0;                      // Wiped after reset
		for (int i = 0; i < 8; i++)
			model_regs[i] = '0;
		repeat (3) @(posedge clk);
		w_n_reset <= 1'b1;
		fd = $fopen("tb/vdp_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open tb/vdp_input.txt");
			failures++;
		end
		else begin
			code = $fscanf(fd, "%s", op);
			while (code == 1 && failures == 0) begin
				if (op == "#") begin                   // Comment line skipped to its end
					c = $fgetc(fd);
					while (c != 10 && c != -1)
						c = $fgetc(fd);
				end
				else begin
					code = $fscanf(fd, "%h %h %h", port_f, value, expv);
					record++;
					if (code != 3) begin
						$display("Record %0d is incomplete", record);
						failures++;
					end
					else
						run_record(op, port_t'(port_f), value, vdp_data_t'(expv), record);
				end
				code = $fscanf(fd, "%s", op);
			end
			$fclose(fd);
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- tb/vdp_input.txt
# op port value expected, hex after the op letter
# W write, R read and check, P model byte at address value, V wait vsync fall, F check frame
# Reads while the wipe runs, 0xFFF then 0x000
W 1 FF 00
W 1 0F 00
R 0 00 00
R 0 00 00
# Burst across the top of VRAM, read back after a new address set
W 1 FE 00
W 1 0F 00
W 0 A1 00
W 0 A2 00
W 0 A3 00
W 1 FE 00
W 1 0F 00
R 0 00 A1
R 0 00 A2
R 0 00 A3
P 0 FFF A2
P 0 000 A3
# Vblank flag, cleared by its own read
V 0 00 00
R 1 00 80
R 1 00 00
# Name page 1, backdrop 0x25, display on, three bytes at the top left
W 1 01 00
W 1 82 00
W 1 25 00
W 1 87 00
W 1 40 00
W 1 81 00
W 1 00 00
W 1 04 00
W 0 E0 00
W 0 00 00
W 0 5B 00
F 0 00 00
# Display off, backdrop everywhere
W 1 00 00
W 1 81 00
F 0 00 00

//--- filelist.f
src/vdp_pkg.sv
src/cart_bus_sync.sv
src/vdp_port.sv
src/vram_sequencer.sv
src/video_timing.sv
src/vdp_cart_top.sv
tb/tb_vdp_cart.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the fail message in the log
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_vdp_cart \
	-f filelist.f -o sim_vdp > build.log 2>&1 \
	&& ./obj_dir/sim_vdp > sim.log 2>&1 \
	|| { echo "Build or simulation did not complete"; cat build.log; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "FAIL"; exit 1; }
echo "PASS"
